// File: include/cpu_macros.svh
`ifndef CPU_MACROS_SVH
`define CPU_MACROS_SVH

// ram depth, in 128-bit lines
`define MEM_LINES 256

// first fetch address once run goes high
`define RESET_PC 32'h0000_0000

// longest wait for an ack, in clock cycles
`define ACK_TIMEOUT 32

`endif

// File: source/cpu_pkg.sv
`include "cpu_macros.svh"

package cpu_pkg;

   // line index width follows the ram depth
   localparam int LINE_AW = $clog2(`MEM_LINES);

   typedef logic [31:0] word_t;
   // four words per line, word 0 in the low bits
   typedef logic [127:0] line_t;
   typedef logic [LINE_AW-1:0] line_addr_t;

   // rv32i major opcodes
   localparam logic [6:0] OPC_LUI    = 7'b0110111;
   localparam logic [6:0] OPC_OPIMM  = 7'b0010011;
   localparam logic [6:0] OPC_OP     = 7'b0110011;
   localparam logic [6:0] OPC_LOAD   = 7'b0000011;
   localparam logic [6:0] OPC_STORE  = 7'b0100011;
   localparam logic [6:0] OPC_BRANCH = 7'b1100011;
   localparam logic [6:0] OPC_JAL    = 7'b1101111;

   typedef enum logic [3:0] {
      op_lui,
      op_addi,
      op_xori,
      op_add,
      op_sub,
      op_xor,
      op_and,
      op_or,
      op_lw,
      op_sw,
      op_beq,
      op_bne,
      op_jal,
      op_illegal
   } op_t;

   // pick one 32-bit word out of a line
   function automatic word_t line_word(input line_t line, input logic [1:0] idx);
      return line[idx*32 +: 32];
   endfunction

endpackage

// File: source/mem_if.sv
`timescale 1ns/1ps

interface mem_if;
   import cpu_pkg::*;

   // request side, held stable until ack
   logic       req;
   logic       we;
   line_addr_t addr;
   line_t      wdata;
   // one strobe bit per word of the line
   logic [3:0] wstrb;

   // response side, rdata valid only with ack
   line_t      rdata;
   logic       ack;

   modport client (output req, we, addr, wdata, wstrb, input rdata, ack);
   modport server (input req, we, addr, wdata, wstrb, output rdata, ack);

endinterface

// File: source/line_ram.sv
`timescale 1ns/1ps
`include "cpu_macros.svh"

module line_ram (
   input logic   CLK,
   input logic   rst_n,
   mem_if.server mem
);
   import cpu_pkg::*;

   line_t data [`MEM_LINES];
   logic  ack_q;
   line_t rdata_q;

   // one ack per request, never two back to back
   always_ff @(posedge CLK or negedge rst_n) begin
      if (!rst_n) begin
         ack_q <= 1'b0;
      end else begin
         ack_q <= mem.req & ~ack_q;
      end
   end

   // read old line, write only strobed words
   always_ff @(posedge CLK) begin
      if (mem.req && !ack_q) begin
         rdata_q <= data[mem.addr];
         if (mem.we) begin
            for (int w = 0; w < 4; w++) begin
               if (mem.wstrb[w]) begin
                  data[mem.addr][w*32 +: 32] <= mem.wdata[w*32 +: 32];
               end
            end
         end
      end
   end

   assign mem.ack   = ack_q;
   assign mem.rdata = rdata_q;

endmodule

// File: source/mem_arbiter.sv
`timescale 1ns/1ps
`include "cpu_macros.svh"

module mem_arbiter (
   input  logic  CLK,
   input  logic  rst_n,
   mem_if.server load_bus,
   mem_if.server ifetch_bus,
   mem_if.server data_bus,
   mem_if.client ram_bus,
   output logic  stall
);
   import cpu_pkg::*;

   // grant codes double as bit positions in pend and acks
   localparam logic [1:0] GNT_LOAD  = 2'd0;
   localparam logic [1:0] GNT_DATA  = 2'd1;
   localparam logic [1:0] GNT_FETCH = 2'd2;
   localparam int         WAIT_W    = $clog2(`ACK_TIMEOUT + 2) + 1;

   logic              busy;
   logic [1:0]        gnt;
   logic [2:0]        pend;
   logic [2:0]        acks;
   logic              watch_vld;
   logic [1:0]        watch;
   logic [WAIT_W-1:0] wait_cnt;

   assign pend = {ifetch_bus.req, data_bus.req, load_bus.req};
   // ack goes to the winner only
   assign acks = busy ? (3'(ram_bus.ack) << gnt) : 3'b000;

   // winner registered in idle, held until ram ack
   always_ff @(posedge CLK or negedge rst_n) begin
      if (!rst_n) begin
         busy <= 1'b0;
         gnt  <= GNT_LOAD;
      end else if (!busy) begin
         busy <= |pend;
         if (pend[GNT_LOAD]) gnt <= GNT_LOAD;
         else if (pend[GNT_DATA]) gnt <= GNT_DATA;
         else gnt <= GNT_FETCH;
      end else if (ram_bus.ack) begin
         busy <= 1'b0;
      end
   end

   // forward the granted client onto the ram channel
   always_comb begin
      ram_bus.req   = 1'b0;
      ram_bus.we    = 1'b0;
      ram_bus.addr  = '0;
      ram_bus.wdata = '0;
      ram_bus.wstrb = 4'b0000;
      if (busy) begin
         case (gnt)
            GNT_LOAD: begin
               ram_bus.req   = load_bus.req;
               ram_bus.we    = load_bus.we;
               ram_bus.addr  = load_bus.addr;
               ram_bus.wdata = load_bus.wdata;
               ram_bus.wstrb = load_bus.wstrb;
            end
            GNT_DATA: begin
               ram_bus.req   = data_bus.req;
               ram_bus.we    = data_bus.we;
               ram_bus.addr  = data_bus.addr;
               ram_bus.wdata = data_bus.wdata;
               ram_bus.wstrb = data_bus.wstrb;
            end
            default: begin
               ram_bus.req   = ifetch_bus.req;
               ram_bus.we    = ifetch_bus.we;
               ram_bus.addr  = ifetch_bus.addr;
               ram_bus.wdata = ifetch_bus.wdata;
               ram_bus.wstrb = ifetch_bus.wstrb;
            end
         endcase
      end
   end

   assign load_bus.ack     = acks[GNT_LOAD];
   assign data_bus.ack     = acks[GNT_DATA];
   assign ifetch_bus.ack   = acks[GNT_FETCH];
   assign load_bus.rdata   = acks[GNT_LOAD] ? ram_bus.rdata : '0;
   assign data_bus.rdata   = acks[GNT_DATA] ? ram_bus.rdata : '0;
   assign ifetch_bus.rdata = acks[GNT_FETCH] ? ram_bus.rdata : '0;

   // watch one waiting client, lowest priority first when several arrive together
   always_ff @(posedge CLK or negedge rst_n) begin
      if (!rst_n) begin
         watch_vld <= 1'b0;
         watch     <= GNT_LOAD;
         wait_cnt  <= '0;
         stall     <= 1'b0;
      end else begin
         if (!watch_vld) begin
            watch_vld <= |pend;
            wait_cnt  <= '0;
            if (pend[GNT_FETCH]) watch <= GNT_FETCH;
            else if (pend[GNT_DATA]) watch <= GNT_DATA;
            else watch <= GNT_LOAD;
         end else if (acks[watch]) begin
            watch_vld <= 1'b0;
         end else if (wait_cnt <= `ACK_TIMEOUT) begin
            wait_cnt <= wait_cnt + 1'b1;
         end
         // sticky until reset
         if (wait_cnt > `ACK_TIMEOUT) stall <= 1'b1;
      end
   end

endmodule

// File: source/fetch_unit.sv
`timescale 1ns/1ps

module fetch_unit (
   input  logic           CLK,
   input  logic           rst_n,
   input  logic           run,
   input  cpu_pkg::word_t fetch_pc,
   input  logic           fetch_go,
   output cpu_pkg::word_t instr,
   output logic           instr_valid,
   mem_if.client          ifetch_bus
);
   import cpu_pkg::*;

   line_t      line_buf;
   line_addr_t tag;
   line_addr_t pc_line;
   line_addr_t miss_addr;
   logic [1:0] word_sel;
   logic       buf_vld;
   logic       run_q;
   logic       req_q;
   logic       hit;

   assign pc_line = fetch_pc[LINE_AW+3:4];
   assign hit     = buf_vld && (tag == pc_line);

   always_ff @(posedge CLK or negedge rst_n) begin
      if (!rst_n) begin
         run_q       <= 1'b0;
         buf_vld     <= 1'b0;
         req_q       <= 1'b0;
         instr_valid <= 1'b0;
      end else begin
         run_q       <= run;
         instr_valid <= 1'b0;
         // program may have changed while run was low
         if (run && !run_q) buf_vld <= 1'b0;
         if (fetch_go && hit) instr_valid <= 1'b1;
         else if (fetch_go) req_q <= 1'b1;
         // refill done, buffer valid again
         if (req_q && ifetch_bus.ack) begin
            req_q       <= 1'b0;
            buf_vld     <= 1'b1;
            instr_valid <= 1'b1;
         end
      end
   end

   // line buffer and instruction word
   always_ff @(posedge CLK) begin
      if (fetch_go) begin
         word_sel  <= fetch_pc[3:2];
         miss_addr <= pc_line;
         instr     <= line_word(line_buf, fetch_pc[3:2]);
      end
      if (req_q && ifetch_bus.ack) begin
         line_buf <= ifetch_bus.rdata;
         tag      <= miss_addr;
         instr    <= line_word(ifetch_bus.rdata, word_sel);
      end
   end

   // read only channel
   assign ifetch_bus.req   = req_q;
   assign ifetch_bus.we    = 1'b0;
   assign ifetch_bus.addr  = miss_addr;
   assign ifetch_bus.wdata = '0;
   assign ifetch_bus.wstrb = 4'b0000;

endmodule

// File: source/load_store_unit.sv
`timescale 1ns/1ps

module load_store_unit (
   input  logic           CLK,
   input  logic           rst_n,
   input  logic           ls_go,
   input  logic           ls_we,
   input  cpu_pkg::word_t ls_addr,
   input  cpu_pkg::word_t ls_wdata,
   output cpu_pkg::word_t ls_rdata,
   output logic           ls_done,
   mem_if.client          data_bus
);
   import cpu_pkg::*;

   logic       req_q;
   logic       we_q;
   line_addr_t addr_q;
   line_t      wdata_q;
   logic [3:0] wstrb_q;
   logic [1:0] word_sel;

   always_ff @(posedge CLK or negedge rst_n) begin
      if (!rst_n) begin
         req_q   <= 1'b0;
         ls_done <= 1'b0;
      end else begin
         ls_done <= 1'b0;
         if (ls_go) req_q <= 1'b1;
         if (req_q && data_bus.ack) begin
            req_q   <= 1'b0;
            ls_done <= 1'b1;
         end
      end
   end

   // request payload, captured on ls_go
   always_ff @(posedge CLK) begin
      if (ls_go) begin
         we_q     <= ls_we;
         addr_q   <= ls_addr[LINE_AW+3:4];
         word_sel <= ls_addr[3:2];
         // same word in every lane, strobe picks the real one
         wdata_q  <= {4{ls_wdata}};
         wstrb_q  <= ls_we ? (4'b0001 << ls_addr[3:2]) : 4'b0000;
      end
      if (req_q && data_bus.ack) ls_rdata <= line_word(data_bus.rdata, word_sel);
   end

   assign data_bus.req   = req_q;
   assign data_bus.we    = we_q;
   assign data_bus.addr  = addr_q;
   assign data_bus.wdata = wdata_q;
   assign data_bus.wstrb = wstrb_q;

endmodule

// File: source/core_exec.sv
`timescale 1ns/1ps
`include "cpu_macros.svh"

module core_exec (
   input  logic           CLK,
   input  logic           rst_n,
   input  logic           run,
   output cpu_pkg::word_t fetch_pc,
   output logic           fetch_go,
   input  cpu_pkg::word_t instr,
   input  logic           instr_valid,
   output logic           ls_go,
   output logic           ls_we,
   output cpu_pkg::word_t ls_addr,
   output cpu_pkg::word_t ls_wdata,
   input  cpu_pkg::word_t ls_rdata,
   input  logic           ls_done,
   output logic           retire,
   output cpu_pkg::word_t retire_pc,
   output logic [4:0]     retire_rd,
   output cpu_pkg::word_t retire_value,
   output logic           halted
);
   import cpu_pkg::*;

   typedef enum logic [2:0] {S_IDLE, S_FETCH, S_EXEC, S_MEM, S_WB, S_HALT} state_t;

   state_t     state;
   word_t      pc, ir, next_pc, result;
   word_t      rf [32];
   logic       wr_en, halt_req, taken, writes_rd;
   op_t        op;
   logic [4:0] rd, rs1, rs2;
   word_t      rs1_val, rs2_val, alu_out, target;
   word_t      imm_i, imm_s, imm_b, imm_u, imm_j;

   assign fetch_pc = pc;
   assign rd       = ir[11:7];
   assign rs1      = ir[19:15];
   assign rs2      = ir[24:20];
   // x0 always reads zero
   assign rs1_val  = (rs1 == 5'd0) ? '0 : rf[rs1];
   assign rs2_val  = (rs2 == 5'd0) ? '0 : rf[rs2];

   // immediate formats
   assign imm_i = {{20{ir[31]}}, ir[31:20]};
   assign imm_s = {{20{ir[31]}}, ir[31:25], ir[11:7]};
   assign imm_b = {{19{ir[31]}}, ir[31], ir[7], ir[30:25], ir[11:8], 1'b0};
   assign imm_u = {ir[31:12], 12'h000};
   assign imm_j = {{11{ir[31]}}, ir[31], ir[19:12], ir[20], ir[30:21], 1'b0};

   // decode to op_t, anything else is illegal
   always_comb begin
      op = op_illegal;
      case (ir[6:0])
         OPC_LUI: op = op_lui;
         OPC_OPIMM: begin
            if (ir[14:12] == 3'b000) op = op_addi;
            else if (ir[14:12] == 3'b100) op = op_xori;
         end
         OPC_OP: begin
            case ({ir[31:25], ir[14:12]})
               10'b0000000_000: op = op_add;
               10'b0100000_000: op = op_sub;
               10'b0000000_100: op = op_xor;
               10'b0000000_110: op = op_or;
               10'b0000000_111: op = op_and;
               default: op = op_illegal;
            endcase
         end
         OPC_LOAD: if (ir[14:12] == 3'b010) op = op_lw;
         OPC_STORE: if (ir[14:12] == 3'b010) op = op_sw;
         OPC_BRANCH: begin
            if (ir[14:12] == 3'b000) op = op_beq;
            else if (ir[14:12] == 3'b001) op = op_bne;
         end
         OPC_JAL: op = op_jal;
         default: op = op_illegal;
      endcase
   end

   // alu and branch
   always_comb begin
      case (op)
         op_lui:  alu_out = imm_u;
         op_addi: alu_out = rs1_val + imm_i;
         op_xori: alu_out = rs1_val ^ imm_i;
         op_add:  alu_out = rs1_val + rs2_val;
         op_sub:  alu_out = rs1_val - rs2_val;
         op_xor:  alu_out = rs1_val ^ rs2_val;
         op_and:  alu_out = rs1_val & rs2_val;
         op_or:   alu_out = rs1_val | rs2_val;
         op_jal:  alu_out = pc + 32'd4;
         default: alu_out = '0;
      endcase
      taken     = (op == op_jal) || (op == op_beq && rs1_val == rs2_val) ||
                  (op == op_bne && rs1_val != rs2_val);
      target    = (op == op_jal) ? pc + imm_j : pc + imm_b;
      writes_rd = op inside {op_lui, op_addi, op_xori, op_add, op_sub, op_xor,
                             op_and, op_or, op_lw, op_jal};
   end

   // control fsm
   always_ff @(posedge CLK or negedge rst_n) begin
      if (!rst_n) begin
         state        <= S_IDLE;
         pc           <= `RESET_PC;
         ir           <= '0;
         next_pc      <= '0;
         result       <= '0;
         wr_en        <= 1'b0;
         halt_req     <= 1'b0;
         fetch_go     <= 1'b0;
         ls_go        <= 1'b0;
         ls_we        <= 1'b0;
         ls_addr      <= '0;
         ls_wdata     <= '0;
         retire       <= 1'b0;
         retire_pc    <= '0;
         retire_rd    <= 5'd0;
         retire_value <= '0;
         halted       <= 1'b0;
      end else begin
         fetch_go <= 1'b0;
         ls_go    <= 1'b0;
         retire   <= 1'b0;
         case (state)
            S_IDLE: begin
               if (run) begin
                  fetch_go <= 1'b1;
                  state    <= S_FETCH;
               end
            end
            S_FETCH: begin
               if (instr_valid) begin
                  ir    <= instr;
                  state <= S_EXEC;
               end
            end
            S_EXEC: begin
               result   <= alu_out;
               wr_en    <= writes_rd;
               // self jump or bad opcode ends the run
               halt_req <= (op == op_illegal) || (op == op_jal && imm_j == '0);
               next_pc  <= taken ? target : pc + 32'd4;
               if (op == op_lw || op == op_sw) begin
                  ls_go    <= 1'b1;
                  ls_we    <= (op == op_sw);
                  ls_addr  <= rs1_val + ((op == op_sw) ? imm_s : imm_i);
                  ls_wdata <= rs2_val;
                  state    <= S_MEM;
               end else begin
                  state <= S_WB;
               end
            end
            S_MEM: begin
               if (ls_done) begin
                  if (!ls_we) result <= ls_rdata;
                  state <= S_WB;
               end
            end
            S_WB: begin
               retire       <= 1'b1;
               retire_pc    <= pc;
               retire_rd    <= wr_en ? rd : 5'd0;
               retire_value <= (wr_en && rd != 5'd0) ? result : '0;
               pc           <= next_pc;
               if (halt_req) begin
                  halted <= 1'b1;
                  state  <= S_HALT;
               end else begin
                  fetch_go <= 1'b1;
                  state    <= S_FETCH;
               end
            end
            default: state <= S_HALT;
         endcase
      end
   end

   // register file, written at retire
   always_ff @(posedge CLK or negedge rst_n) begin
      if (!rst_n) begin
         for (int i = 0; i < 32; i++) rf[i] <= '0;
      end else if (state == S_WB && wr_en && rd != 5'd0) begin
         rf[rd] <= result;
      end
   end

endmodule

// File: source/cpu_wrapper.sv
`timescale 1ns/1ps

module cpu_wrapper (
   input  logic                CLK,
   input  logic                rst_n,
   input  logic                run,
   input  logic                ld_req,
   input  cpu_pkg::line_addr_t ld_addr,
   input  cpu_pkg::line_t      ld_data,
   output logic                ld_ack,
   output logic                retire,
   output cpu_pkg::word_t      retire_pc,
   output logic [4:0]          retire_rd,
   output cpu_pkg::word_t      retire_value,
   output logic                halted,
   output logic                stall
);
   import cpu_pkg::*;

   mem_if load_bus ();
   mem_if ifetch_bus ();
   mem_if data_bus ();
   mem_if ram_bus ();

   word_t fetch_pc, instr, ls_addr, ls_wdata, ls_rdata;
   logic  fetch_go, instr_valid, ls_go, ls_we, ls_done;

   // loader writes whole lines
   assign load_bus.req   = ld_req;
   assign load_bus.we    = 1'b1;
   assign load_bus.addr  = ld_addr;
   assign load_bus.wdata = ld_data;
   assign load_bus.wstrb = 4'b1111;
   assign ld_ack         = load_bus.ack;

   mem_arbiter u_arb (.CLK, .rst_n, .load_bus, .ifetch_bus, .data_bus, .ram_bus, .stall);

   line_ram u_ram (.CLK, .rst_n, .mem(ram_bus));

   fetch_unit u_fetch (.CLK, .rst_n, .run, .fetch_pc, .fetch_go, .instr, .instr_valid,
                       .ifetch_bus);

   load_store_unit u_lsu (.CLK, .rst_n, .ls_go, .ls_we, .ls_addr, .ls_wdata, .ls_rdata,
                          .ls_done, .data_bus);

   core_exec u_core (.CLK, .rst_n, .run, .fetch_pc, .fetch_go, .instr, .instr_valid,
                     .ls_go, .ls_we, .ls_addr, .ls_wdata, .ls_rdata, .ls_done, .retire,
                     .retire_pc, .retire_rd, .retire_value, .halted);

endmodule

// File: tb/cpu_tb.sv
`timescale 1ns/1ps
`include "cpu_macros.svh"

module cpu_tb;
   import cpu_pkg::*;

   localparam int PROG_LEN   = 40;
   localparam int WAIT_LIMIT = `ACK_TIMEOUT * 20;

   logic       CLK;
   logic       rst_n;
   logic       run;
   logic       ld_req;
   line_addr_t ld_addr;
   line_t      ld_data;
   logic       ld_ack;
   logic       retire;
   word_t      retire_pc;
   logic [4:0] retire_rd;
   word_t      retire_value;
   logic       halted;
   logic       stall;

   // generated program, kept as fields and as encoded words
   op_t        p_op  [PROG_LEN];
   logic [4:0] p_rd  [PROG_LEN];
   logic [4:0] p_rs1 [PROG_LEN];
   logic [4:0] p_rs2 [PROG_LEN];
   word_t      p_imm [PROG_LEN];
   word_t      prog  [PROG_LEN];

   // reference model state, memory covers the whole 4 KB ram
   word_t mregs    [32];
   word_t mem_word [1024];
   word_t mpc;

   logic [15:0] lfsr    = 16'd92;
   int          retired = 0;
   int          loads   = 0;
   int          ld_acks = 0;

   cpu_wrapper DUT (.CLK, .rst_n, .run, .ld_req, .ld_addr, .ld_data, .ld_ack, .retire,
                    .retire_pc, .retire_rd, .retire_value, .halted, .stall);

   initial begin
      CLK = 1'b0;
      forever #20 CLK = ~CLK;
   end

   // every cycle of ack counts, so a long ack shows up too
   always @(negedge CLK) begin
      if (ld_ack) ld_acks <= ld_acks + 1;
   end

   // x16 + x14 + x13 + x11 + 1
   function automatic logic [15:0] lfsr_step(input logic [15:0] s);
      return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
   endfunction

   // one lfsr step per bit taken
   function automatic word_t rand_bits(input int n);
      word_t v;
      v = '0;
      for (int b = 0; b < n; b++) begin
         lfsr = lfsr_step(lfsr);
         v    = {v[30:0], lfsr[0]};
      end
      return v;
   endfunction

   function automatic word_t fill_word(input word_t a);
      return {a[15:0] ^ 16'hc35a, ~a[15:0]};
   endfunction

   function automatic line_t data_line(input int l);
      line_t d;
      for (int w = 0; w < 4; w++) d[w*32 +: 32] = fill_word(word_t'(l * 16 + w * 4));
      return d;
   endfunction

   // rv32i encodings straight from the isa formats
   function automatic word_t encode(input op_t op, input logic [4:0] rd, input logic [4:0] rs1,
                                    input logic [4:0] rs2, input word_t imm);
      case (op)
         op_lui:  return {imm[31:12], rd, 7'b0110111};
         op_addi: return {imm[11:0], rs1, 3'b000, rd, 7'b0010011};
         op_xori: return {imm[11:0], rs1, 3'b100, rd, 7'b0010011};
         op_add:  return {7'b0000000, rs2, rs1, 3'b000, rd, 7'b0110011};
         op_sub:  return {7'b0100000, rs2, rs1, 3'b000, rd, 7'b0110011};
         op_xor:  return {7'b0000000, rs2, rs1, 3'b100, rd, 7'b0110011};
         op_or:   return {7'b0000000, rs2, rs1, 3'b110, rd, 7'b0110011};
         op_and:  return {7'b0000000, rs2, rs1, 3'b111, rd, 7'b0110011};
         op_lw:   return {imm[11:0], rs1, 3'b010, rd, 7'b0000011};
         op_sw:   return {imm[11:5], rs2, rs1, 3'b010, imm[4:0], 7'b0100011};
         op_beq:  return {imm[12], imm[10:5], rs2, rs1, 3'b000, imm[4:1], imm[11], 7'b1100011};
         op_bne:  return {imm[12], imm[10:5], rs2, rs1, 3'b001, imm[4:1], imm[11], 7'b1100011};
         op_jal:  return {imm[20], imm[10:1], imm[11], imm[19:12], rd, 7'b1101111};
         default: return '0;
      endcase
   endfunction

   task automatic report_failure(input string why);
      $display("%s", why);
      $display("Simulation failed");
      $fatal(1);
   endtask

   task automatic check(input string name, input word_t got, input word_t exp);
      if (got !== exp) begin
         report_failure($sformatf("Mismatch %s: got 0x%08h, expected 0x%08h", name, got, exp));
      end
   endtask

   task automatic build_program();
      int    k;
      word_t r;
      for (int i = 0; i < PROG_LEN; i++) begin
         p_rd[i]  = 5'(rand_bits(3));
         p_rs1[i] = 5'(rand_bits(3));
         p_rs2[i] = 5'(rand_bits(3));
         p_op[i]  = op_t'(rand_bits(4) % 13);
         p_imm[i] = '0;
         case (p_op[i])
            op_lui: begin
               r        = rand_bits(20);
               p_imm[i] = r << 12;
            end
            op_addi, op_xori: begin
               r        = rand_bits(12);
               p_imm[i] = {{20{r[11]}}, r[11:0]};
            end
            // x8 holds 0x7fc, so offsets land on lines 128 and 129
            op_lw, op_sw: begin
               p_rs1[i] = 5'd8;
               p_imm[i] = 4 + 4 * rand_bits(3);
            end
            // forward only, never past the final jal
            op_beq, op_bne, op_jal: begin
               k = int'(rand_bits(2)) + 1;
               if (i + k > PROG_LEN - 1) k = PROG_LEN - 1 - i;
               p_imm[i] = word_t'(4 * k);
            end
            default: ;
         endcase
         // base register setup first, self jump last
         if (i == 0) begin
            p_op[i]  = op_addi;
            p_rd[i]  = 5'd8;
            p_rs1[i] = 5'd0;
            p_imm[i] = 32'h0000_07fc;
         end else if (i == PROG_LEN - 1) begin
            p_op[i]  = op_jal;
            p_rd[i]  = 5'd0;
            p_imm[i] = '0;
         end
         prog[i] = encode(p_op[i], p_rd[i], p_rs1[i], p_rs2[i], p_imm[i]);
      end
      mpc = `RESET_PC;
      for (int x = 0; x < 32; x++) mregs[x] = '0;
      for (int w = 0; w < 1024; w++) mem_word[w] = fill_word(word_t'(w * 4));
      for (int i = 0; i < PROG_LEN; i++) mem_word[i] = prog[i];
   endtask

   // one instruction of the reference model
   task automatic model_step(output word_t pc_o, output logic [4:0] rd_o,
                             output word_t val_o, output logic halt_o);
      int    i;
      word_t a, b, val, nxt, addr;
      logic  wr;
      i      = int'(mpc[31:2]);
      a      = mregs[p_rs1[i]];
      b      = mregs[p_rs2[i]];
      addr   = a + p_imm[i];
      val    = '0;
      wr     = 1'b1;
      nxt    = mpc + 4;
      halt_o = 1'b0;
      case (p_op[i])
         op_lui:  val = p_imm[i];
         op_addi: val = a + p_imm[i];
         op_xori: val = a ^ p_imm[i];
         op_add:  val = a + b;
         op_sub:  val = a - b;
         op_xor:  val = a ^ b;
         op_and:  val = a & b;
         op_or:   val = a | b;
         op_lw:   val = mem_word[addr[11:2]];
         op_sw: begin
            // only the addressed word changes
            mem_word[addr[11:2]] = b;
            wr = 1'b0;
         end
         op_beq: begin
            wr = 1'b0;
            if (a == b) nxt = mpc + p_imm[i];
         end
         op_bne: begin
            wr = 1'b0;
            if (a != b) nxt = mpc + p_imm[i];
         end
         op_jal: begin
            val    = mpc + 4;
            nxt    = mpc + p_imm[i];
            halt_o = (p_imm[i] == '0);
         end
         default: wr = 1'b0;
      endcase
      pc_o  = mpc;
      rd_o  = wr ? p_rd[i] : 5'd0;
      val_o = (wr && p_rd[i] != 5'd0) ? val : '0;
      if (wr && p_rd[i] != 5'd0) mregs[p_rd[i]] = val;
      mpc = nxt;
   endtask

   // one line through the loader port, req held until ack
   task automatic load_line(input line_addr_t a, input line_t d);
      int n;
      @(posedge CLK);
      ld_req  <= 1'b1;
      ld_addr <= a;
      ld_data <= d;
      n = 0;
      do begin
         @(negedge CLK);
         n++;
      end while (!ld_ack && n < WAIT_LIMIT);
      if (!ld_ack) report_failure($sformatf("No ld_ack arrived for the load of line %0d", a));
      loads++;
      @(posedge CLK);
      ld_req <= 1'b0;
   endtask

   task automatic check_retires();
      int         n;
      word_t      epc, eval;
      logic [4:0] erd;
      logic       ehalt;
      ehalt = 1'b0;
      while (!ehalt) begin
         n = 0;
         do begin
            @(negedge CLK);
            n++;
         end while (!retire && n < WAIT_LIMIT);
         if (!retire) report_failure($sformatf("No retire after %0d instructions", retired));
         model_step(epc, erd, eval, ehalt);
         check("retire_pc", retire_pc, epc);
         check("retire_rd", 32'(retire_rd), 32'(erd));
         check("retire_value", retire_value, eval);
         check("halted", 32'(halted), 32'(ehalt));
         check("stall", 32'(stall), 32'd0);
         retired++;
      end
   endtask

   // loader cuts in while the core is busy
   task automatic load_during_run();
      int n;
      n = 0;
      while (retired < 5 && n < WAIT_LIMIT) begin
         @(negedge CLK);
         n++;
      end
      if (retired < 5) report_failure("The core did not retire five instructions in time");
      load_line(line_addr_t'(200), data_line(200));
   endtask

   initial begin
      int n;
      rst_n   = 1'b0;
      run     = 1'b0;
      ld_req  = 1'b0;
      ld_addr = '0;
      ld_data = '0;
      build_program();
      repeat (3) @(posedge CLK);
      rst_n <= 1'b1;
      // program lines, word 0 in the low bits
      for (int l = 0; l < PROG_LEN / 4; l++) begin
         load_line(line_addr_t'(l), {prog[4*l+3], prog[4*l+2], prog[4*l+1], prog[4*l]});
      end
      load_line(line_addr_t'(128), data_line(128));
      load_line(line_addr_t'(129), data_line(129));
      @(posedge CLK);
      run <= 1'b1;
      fork
         check_retires();
         load_during_run();
      join
      n = 0;
      while (!halted && n < WAIT_LIMIT) begin
         @(negedge CLK);
         n++;
      end
      if (!halted) report_failure("The core did not halt after the self jump");
      // quiet after halt
      repeat (20) begin
         @(negedge CLK);
         check("retire", 32'(retire), 32'd0);
      end
      check("stall", 32'(stall), 32'd0);
      check("ld_ack count", 32'(ld_acks), 32'(loads));
      $display("Simulation passed");
      $finish;
   end

endmodule

// File: compile.f
+incdir+include
source/cpu_pkg.sv
source/mem_if.sv
source/line_ram.sv
source/mem_arbiter.sv
source/fetch_unit.sv
source/load_store_unit.sv
source/core_exec.sv
source/cpu_wrapper.sv
tb/cpu_tb.sv

// File: Makefile
TOP := cpu_tb
LOG := sim.log

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing -f compile.f --top-module $(TOP)

# the log decides pass or fail, not the exit status of the run
sim:
	verilator --binary --timing -f compile.f --top-module $(TOP) -Mdir obj_dir
	./obj_dir/V$(TOP) > $(LOG) 2>&1 || true
	cat $(LOG)
	grep -q "^Simulation passed$$" $(LOG)

clean:
	rm -rf obj_dir $(LOG)
